// File: mpeg_sys_demux.f
mpeg_sys_pkg.sv
bit_deserializer.sv
start_code_decode.sv
pack_header_parse.sv
system_header_parse.sv
packet_parse.sv
mpeg_sys_demux.sv
tb_mpeg_sys_demux.sv

// File: tb_mpeg_sys_demux.sv
// directed testbench for the MPEG-1 system demux, compiled with the file list from the project root
`timescale 1ns/1ps
`default_nettype none

module tb_mpeg_sys_demux;

	localparam int RESET_CYCLES = 5;
	localparam int SETTLE_LIMIT = 64; // cycles to wait for the expected records
	localparam int DRAIN_CYCLES = 16; // extra cycles to catch stray records
	localparam int NUM_TESTS    = 6;
	localparam int IDLE_GAP     = 3;
	// bytes per test: two packs, system, packet, padding + packet, idle run, garbage + end
	localparam int TEST_BYTES   = 24 + 18 + 40 + 28 + 36 + 41;
	localparam int IDLE_CYCLES  = 36 * IDLE_GAP;
	localparam int LIMIT_NS     = TEST_BYTES * 8 * 4 * 2
		+ (IDLE_CYCLES + RESET_CYCLES + NUM_TESTS * (SETTLE_LIMIT + DRAIN_CYCLES)) * 4;

	logic clk;
	logic arst_n;
	logic bit_en;
	logic bit_in;
	mpeg_sys_pkg::pack_info_t    pack_info;
	logic                        pack_valid;
	mpeg_sys_pkg::sys_info_t     sys_info;
	logic                        sys_valid;
	mpeg_sys_pkg::stream_bound_t stream_bound;
	logic                        bound_valid;
	mpeg_sys_pkg::time_stamp_t   time_stamp;
	logic                        ts_valid;
	mpeg_sys_pkg::payload_t      payload;
	logic                        payload_valid;
	logic                        stream_end;

	logic [7:0] stream[$]; // bytes still to be sent
	mpeg_sys_pkg::pack_info_t    got_pack[$];
	mpeg_sys_pkg::pack_info_t    exp_pack[$];
	mpeg_sys_pkg::sys_info_t     got_sys[$];
	mpeg_sys_pkg::sys_info_t     exp_sys[$];
	mpeg_sys_pkg::stream_bound_t got_bound[$];
	mpeg_sys_pkg::stream_bound_t exp_bound[$];
	mpeg_sys_pkg::time_stamp_t   got_ts[$];
	mpeg_sys_pkg::time_stamp_t   exp_ts[$];
	mpeg_sys_pkg::payload_t      got_pay[$];
	mpeg_sys_pkg::payload_t      exp_pay[$];
	int     end_count;
	int     exp_end;
	int     errors;
	int     start_errors;
	int     tests_run;
	int     tests_failed;
	int     idle_gap;
	integer seed;

	mpeg_sys_demux #(
		.LSB_FIRST (1'b1)
	) dut0 (
		.clk           (clk),
		.arst_n        (arst_n),
		.bit_en        (bit_en),
		.bit_in        (bit_in),
		.pack_info     (pack_info),
		.pack_valid    (pack_valid),
		.sys_info      (sys_info),
		.sys_valid     (sys_valid),
		.stream_bound  (stream_bound),
		.bound_valid   (bound_valid),
		.time_stamp    (time_stamp),
		.ts_valid      (ts_valid),
		.payload       (payload),
		.payload_valid (payload_valid),
		.stream_end    (stream_end)
	);

	initial
		clk = 1'b0;

	always #2 clk = ~clk;

	// records are stable around the falling edge
	always @(negedge clk)
	begin
		if (pack_valid)
			got_pack.push_back(pack_info);
		if (sys_valid)
			got_sys.push_back(sys_info);
		if (bound_valid)
			got_bound.push_back(stream_bound);
		if (ts_valid)
			got_ts.push_back(time_stamp);
		if (payload_valid)
			got_pay.push_back(payload);
		if (stream_end)
			end_count++;
	end

	initial
	begin
		#(LIMIT_NS);
		$display("watchdog expired after %0d ns, the tests did not complete", LIMIT_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	// serial bits go out LSB first, optional idle cycles after bit 3
	task send_byte(input logic [7:0] b);
		int i;
		for (i = 0; i < 8; i++)
		begin
			if ((i == 4) && (idle_gap > 0))
			begin
				@(posedge clk);
				#1 bit_en = 1'b0;
				repeat (idle_gap - 1) @(posedge clk);
			end
			@(posedge clk);
			#1;
			bit_en = 1'b1;
			bit_in = b[i];
		end
	endtask

	task send_stream();
		while (stream.size() > 0)
			send_byte(stream.pop_front());
		@(posedge clk);
		#1 bit_en = 1'b0;
	endtask

	task add_start(input logic [7:0] code);
		stream.push_back(8'h00);
		stream.push_back(8'h00);
		stream.push_back(8'h01);
		stream.push_back(code);
	endtask

	// 5-byte time stamp, marker bits set
	task add_stamp(input logic [3:0] prefix, input logic [32:0] v);
		stream.push_back({prefix, v[32:30], 1'b1});
		stream.push_back(v[29:22]);
		stream.push_back({v[21:15], 1'b1});
		stream.push_back(v[14:7]);
		stream.push_back({v[6:0], 1'b1});
	endtask

	task add_pack(input logic [32:0] scr, input logic [21:0] mux, input bit bad_marker,
		input bit expect_out);
		mpeg_sys_pkg::pack_info_t exp;
		add_start(mpeg_sys_pkg::CODE_PACK);
		stream.push_back({4'b0010, scr[32:30], 1'b1});
		stream.push_back(scr[29:22]);
		stream.push_back({scr[21:15], !bad_marker}); // marker may be cleared here
		stream.push_back(scr[14:7]);
		stream.push_back({scr[6:0], 1'b1});
		stream.push_back({1'b1, mux[21:15]});
		stream.push_back(mux[14:7]);
		stream.push_back({mux[6:0], 1'b1});
		exp.scr        = scr;
		exp.mux_rate   = mux;
		exp.marker_err = bad_marker;
		if (expect_out)
			exp_pack.push_back(exp);
	endtask

	task add_entry(input mpeg_sys_pkg::stream_bound_t e);
		stream.push_back(e.stream_id);
		stream.push_back({2'b11, e.bound_scale, e.bound_size[12:8]});
		stream.push_back(e.bound_size[7:0]);
		exp_bound.push_back(e);
	endtask

	task add_sys(input mpeg_sys_pkg::sys_info_t info, input mpeg_sys_pkg::stream_bound_t a,
		input mpeg_sys_pkg::stream_bound_t b);
		mpeg_sys_pkg::sys_info_t exp;
		exp            = info;
		exp.header_len = 16'd12; // six fixed bytes and two entries
		exp.marker_err = 1'b0;
		add_start(mpeg_sys_pkg::CODE_SYSTEM);
		stream.push_back(exp.header_len[15:8]);
		stream.push_back(exp.header_len[7:0]);
		stream.push_back({1'b1, info.rate_bound[21:15]});
		stream.push_back(info.rate_bound[14:7]);
		stream.push_back({info.rate_bound[6:0], 1'b1});
		stream.push_back({info.audio_bound, info.fixed_flag, info.csps_flag});
		stream.push_back({info.audio_lock, info.video_lock, 1'b1, info.video_bound});
		stream.push_back(8'hFF); // reserved
		exp_sys.push_back(exp);
		add_entry(a);
		add_entry(b);
	endtask

	// packet with stuffing, then STD + PTS + DTS or the 0F no-stamp byte, then random payload
	task add_packet(input logic [7:0] id, input int nstuff, input bit stamps,
		input logic std_scale, input logic [12:0] std_size, input logic [32:0] pts,
		input logic [32:0] dts, input int npay);
		int i;
		int len;
		int rnd;
		mpeg_sys_pkg::time_stamp_t ts;
		mpeg_sys_pkg::payload_t    p;
		len = nstuff + (stamps ? 12 : 1) + npay;
		add_start(id);
		stream.push_back(len[15:8]);
		stream.push_back(len[7:0]);
		for (i = 0; i < nstuff; i++)
			stream.push_back(8'hFF);
		if (stamps)
		begin
			stream.push_back({2'b01, std_scale, std_size[12:8]});
			stream.push_back(std_size[7:0]);
			add_stamp(4'b0011, pts);
			add_stamp(4'b0001, dts);
			ts = '{stream_id: id, pts: pts, dts: dts, has_dts: 1'b1, std_scale: std_scale,
				std_size: std_size, std_valid: 1'b1};
			exp_ts.push_back(ts);
		end
		else
			stream.push_back(8'h0F);
		for (i = 0; i < npay; i++)
		begin
			rnd = $random(seed);
			stream.push_back(rnd[7:0]);
			p.stream_id = id;
			p.data      = rnd[7:0];
			p.last      = (i == npay - 1);
			exp_pay.push_back(p);
		end
	endtask

	task add_padding(input int len);
		int i;
		add_start(mpeg_sys_pkg::STREAM_PADDING);
		stream.push_back(len[15:8]);
		stream.push_back(len[7:0]);
		for (i = 0; i < len; i++)
			stream.push_back(8'hFF);
	endtask

	task check_pack(input mpeg_sys_pkg::pack_info_t got, input mpeg_sys_pkg::pack_info_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR t=%0t pack_info got %h expected %h", $time, got, exp);
		end
	endtask

	task check_sys(input mpeg_sys_pkg::sys_info_t got, input mpeg_sys_pkg::sys_info_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR t=%0t sys_info got %h expected %h", $time, got, exp);
		end
	endtask

	task check_bound(input mpeg_sys_pkg::stream_bound_t got,
		input mpeg_sys_pkg::stream_bound_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR t=%0t stream_bound got %h expected %h", $time, got, exp);
		end
	endtask

	task check_ts(input mpeg_sys_pkg::time_stamp_t got, input mpeg_sys_pkg::time_stamp_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR t=%0t time_stamp got %h expected %h", $time, got, exp);
		end
	endtask

	task check_payload(input mpeg_sys_pkg::payload_t got, input mpeg_sys_pkg::payload_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR t=%0t payload got %h expected %h", $time, got, exp);
		end
	endtask

	task check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			errors++;
			$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task clear_results();
		got_pack.delete();
		exp_pack.delete();
		got_sys.delete();
		exp_sys.delete();
		got_bound.delete();
		exp_bound.delete();
		got_ts.delete();
		exp_ts.delete();
		got_pay.delete();
		exp_pay.delete();
		end_count    = 0;
		exp_end      = 0;
		start_errors = errors;
	endtask

	function automatic bit results_in();
		return (got_pack.size() >= exp_pack.size()) && (got_sys.size() >= exp_sys.size())
			&& (got_bound.size() >= exp_bound.size()) && (got_ts.size() >= exp_ts.size())
			&& (got_pay.size() >= exp_pay.size()) && (end_count >= exp_end);
	endfunction

	task wait_results(input string name);
		int n;
		n = 0;
		while (!results_in() && (n < SETTLE_LIMIT))
		begin
			@(posedge clk);
			n++;
		end
		if (!results_in())
		begin
			errors++;
			$display("%s: expected records did not arrive within %0d cycles", name, SETTLE_LIMIT);
		end
		repeat (DRAIN_CYCLES) @(posedge clk);
	endtask

	task compare_results();
		int i;
		check_count("pack_valid pulses", got_pack.size(), exp_pack.size());
		for (i = 0; (i < got_pack.size()) && (i < exp_pack.size()); i++)
			check_pack(got_pack[i], exp_pack[i]);
		check_count("sys_valid pulses", got_sys.size(), exp_sys.size());
		for (i = 0; (i < got_sys.size()) && (i < exp_sys.size()); i++)
			check_sys(got_sys[i], exp_sys[i]);
		check_count("bound_valid pulses", got_bound.size(), exp_bound.size());
		for (i = 0; (i < got_bound.size()) && (i < exp_bound.size()); i++)
			check_bound(got_bound[i], exp_bound[i]);
		check_count("ts_valid pulses", got_ts.size(), exp_ts.size());
		for (i = 0; (i < got_ts.size()) && (i < exp_ts.size()); i++)
			check_ts(got_ts[i], exp_ts[i]);
		check_count("payload_valid pulses", got_pay.size(), exp_pay.size());
		for (i = 0; (i < got_pay.size()) && (i < exp_pay.size()); i++)
			check_payload(got_pay[i], exp_pay[i]);
		check_count("stream_end pulses", end_count, exp_end);
	endtask

	task finish_test(input string name);
		wait_results(name);
		compare_results();
		tests_run++;
		if (errors == start_errors)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	task pack_header_fields();
		clear_results();
		add_pack(33'h1_2345_6789, 22'h2A_5A5A, 1'b0, 1'b1);
		add_pack(33'h0_F0F0_F0F1, 22'h15_A5A5, 1'b1, 1'b1); // one marker cleared
		send_stream();
		finish_test("pack_header_fields");
	endtask

	task system_header_entries();
		mpeg_sys_pkg::sys_info_t info;
		clear_results();
		info             = '0;
		info.rate_bound  = 22'h1F_0A0F;
		info.audio_bound = 6'd5;
		info.fixed_flag  = 1'b1;
		info.csps_flag   = 1'b0;
		info.audio_lock  = 1'b1;
		info.video_lock  = 1'b0;
		info.video_bound = 5'd3;
		add_sys(info, '{stream_id: 8'hC0, bound_scale: 1'b0, bound_size: 13'h0123},
			'{stream_id: 8'hE0, bound_scale: 1'b1, bound_size: 13'h1ABC});
		send_stream();
		finish_test("system_header_entries");
	endtask

	task packet_with_stamps();
		clear_results();
		add_packet(8'hE0, 2, 1'b1, 1'b1, 13'h0456, 33'h1_DEAD_BEEF, 33'h0_CAFE_F00D, 20);
		send_stream();
		finish_test("packet_with_stamps");
	endtask

	task padding_then_packet();
		clear_results();
		add_padding(6);
		add_packet(8'hC0, 1, 1'b0, 1'b0, 13'h0, 33'h0, 33'h0, 8);
		send_stream();
		finish_test("padding_then_packet");
	endtask

	task idle_gaps_mid_byte();
		clear_results();
		idle_gap = IDLE_GAP;
		add_pack(33'h0_1357_9BDF, 22'h00_0ACE, 1'b0, 1'b1);
		add_packet(8'hE1, 0, 1'b1, 1'b0, 13'h1FFF, 33'h0_0000_0001, 33'h1_FFFF_FFFE, 6);
		send_stream();
		idle_gap = 0;
		finish_test("idle_gaps_mid_byte");
	endtask

	task garbage_and_end();
		clear_results();
		stream.push_back(8'h12);
		stream.push_back(8'h34);
		stream.push_back(8'h00);
		stream.push_back(8'h00);
		stream.push_back(8'h02); // false prefix
		add_start(8'hB5);        // reserved code, back to hunting
		add_pack(33'h0_0ABC_DEF0, 22'h3F_0001, 1'b0, 1'b1);
		stream.push_back(8'h00);
		stream.push_back(8'h00);
		stream.push_back(8'h02);
		stream.push_back(8'hAA);
		add_start(mpeg_sys_pkg::CODE_END);
		exp_end = 1;
		add_pack(33'h1_1111_1111, 22'h01_2345, 1'b0, 1'b0); // ignored after the end code
		send_stream();
		finish_test("garbage_and_end");
	endtask

	initial
	begin
		seed         = 32'h8fac_31a5;
		errors       = 0;
		start_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		idle_gap     = 0;
		end_count    = 0;
		exp_end      = 0;
		bit_en       = 1'b0;
		bit_in       = 1'b0;
		arst_n       = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;

		// outputs idle right after reset
		check_flag("pack_valid", pack_valid, 1'b0);
		check_flag("sys_valid", sys_valid, 1'b0);
		check_flag("bound_valid", bound_valid, 1'b0);
		check_flag("ts_valid", ts_valid, 1'b0);
		check_flag("payload_valid", payload_valid, 1'b0);
		check_flag("stream_end", stream_end, 1'b0);

		pack_header_fields();
		system_header_entries();
		packet_with_stamps();
		padding_then_packet();
		idle_gaps_mid_byte();
		garbage_and_end(); // last, the decoder stays ended

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: mpeg_sys_demux.sv
// top level of the MPEG-1 system stream demux, wires the deserializer, decoder and parsers
`timescale 1ns/1ps
`default_nettype none

module mpeg_sys_demux #(
	parameter bit LSB_FIRST = 1'b1
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        bit_en,
	input  logic                        bit_in,
	output mpeg_sys_pkg::pack_info_t    pack_info,
	output logic                        pack_valid,
	output mpeg_sys_pkg::sys_info_t     sys_info,
	output logic                        sys_valid,
	output mpeg_sys_pkg::stream_bound_t stream_bound,
	output logic                        bound_valid,
	output mpeg_sys_pkg::time_stamp_t   time_stamp,
	output logic                        ts_valid,
	output mpeg_sys_pkg::payload_t      payload,
	output logic                        payload_valid,
	output logic                        stream_end
);

	logic [7:0] data_byte;
	logic       byte_valid;
	logic       pack_sel;
	logic       sys_sel;
	logic       pkt_sel;
	logic       pack_done;
	logic       sys_done;
	logic       pkt_done;
	logic       pkt_start;
	logic [7:0] pkt_stream_id;

	bit_deserializer #(
		.LSB_FIRST (LSB_FIRST)
	) deser0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.bit_en     (bit_en),
		.bit_in     (bit_in),
		.data_byte  (data_byte),
		.byte_valid (byte_valid)
	);

	start_code_decode decode0 (
		.clk           (clk),
		.arst_n        (arst_n),
		.data_byte     (data_byte),
		.byte_valid    (byte_valid),
		.pack_done     (pack_done),
		.sys_done      (sys_done),
		.pkt_done      (pkt_done),
		.pack_sel      (pack_sel),
		.sys_sel       (sys_sel),
		.pkt_sel       (pkt_sel),
		.pkt_start     (pkt_start),
		.pkt_stream_id (pkt_stream_id),
		.stream_end    (stream_end)
	);

	pack_header_parse pack0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.data_byte  (data_byte),
		.pack_sel   (pack_sel),
		.pack_done  (pack_done),
		.pack_info  (pack_info),
		.pack_valid (pack_valid)
	);

	system_header_parse sys0 (
		.clk          (clk),
		.arst_n       (arst_n),
		.data_byte    (data_byte),
		.sys_sel      (sys_sel),
		.sys_done     (sys_done),
		.sys_info     (sys_info),
		.sys_valid    (sys_valid),
		.stream_bound (stream_bound),
		.bound_valid  (bound_valid)
	);

	packet_parse pkt0 (
		.clk           (clk),
		.arst_n        (arst_n),
		.data_byte     (data_byte),
		.pkt_sel       (pkt_sel),
		.pkt_start     (pkt_start),
		.pkt_stream_id (pkt_stream_id),
		.pkt_done      (pkt_done),
		.time_stamp    (time_stamp),
		.ts_valid      (ts_valid),
		.payload       (payload),
		.payload_valid (payload_valid)
	);

endmodule

`default_nettype wire

// File: packet_parse.sv
// parses packet length, stuffing, STD fields and time stamps, then emits the payload bytes
`timescale 1ns/1ps
`default_nettype none

module packet_parse (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [7:0]                data_byte,
	input  logic                      pkt_sel,
	input  logic                      pkt_start,
	input  logic [7:0]                pkt_stream_id,
	output logic                      pkt_done,
	output mpeg_sys_pkg::time_stamp_t time_stamp,
	output logic                      ts_valid,
	output mpeg_sys_pkg::payload_t    payload,
	output logic                      payload_valid
);

	typedef enum logic [2:0]
	{
		LEN_HI,
		LEN_LO,
		STUFF,
		STD_LO,
		STAMP,
		DATA
	} pkt_state_e;

	pkt_state_e  state_q;
	logic        pad_q;    // padding stream, bytes are dropped
	logic [7:0]  len_hi_q;
	logic [15:0] rem_q;    // bytes left after the length field
	logic [3:0]  st_q;     // next time-stamp byte, 1..9
	logic        body;
	logic        last;
	logic        zero_len;
	logic        stamp_done;
	mpeg_sys_pkg::time_stamp_t ts_q;
	mpeg_sys_pkg::time_stamp_t ts_nxt;

	// places one byte of a 5-byte stamp into the 33-bit value, markers dropped
	function automatic logic [32:0] put_stamp(input logic [32:0] ts, input logic [3:0] pos,
		input logic [7:0] b);
		logic [32:0] r;
		r = ts;
		case (pos)
			4'd0: r[32:30] = b[3:1];
			4'd1: r[29:22] = b;
			4'd2: r[21:15] = b[7:1];
			4'd3: r[14:7] = b;
			default: r[6:0] = b[7:1];
		endcase
		return r;
	endfunction

	assign body       = (state_q != LEN_HI) && (state_q != LEN_LO);
	assign last       = body && (rem_q == 16'd1);
	assign zero_len   = (state_q == LEN_LO) && ({len_hi_q, data_byte} == 16'd0);
	assign stamp_done = (state_q == STAMP) && (st_q == (ts_q.has_dts ? 4'd9 : 4'd4));

	always_comb
	begin
		ts_nxt = ts_q;
		if (st_q < 4'd5)
			ts_nxt.pts = put_stamp(ts_q.pts, st_q, data_byte);
		else
			ts_nxt.dts = put_stamp(ts_q.dts, st_q - 4'd5, data_byte);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state_q       <= LEN_HI;
			pad_q         <= 1'b0;
			rem_q         <= '0;
			st_q          <= '0;
			ts_valid      <= 1'b0;
			payload_valid <= 1'b0;
			pkt_done      <= 1'b0;
		end
		else
		begin
			ts_valid      <= pkt_sel && stamp_done;
			payload_valid <= pkt_sel && (state_q == DATA) && !pad_q;
			pkt_done      <= pkt_sel && (last || zero_len);
			if (pkt_start)
			begin
				state_q <= LEN_HI;
				pad_q   <= (pkt_stream_id == mpeg_sys_pkg::STREAM_PADDING);
			end
			else if (pkt_sel)
			begin
				if (body)
					rem_q <= rem_q - 16'd1;
				if (last || zero_len)
					state_q <= LEN_HI;
				else
				begin
					case (state_q)
						LEN_HI: state_q <= LEN_LO;
						LEN_LO:
						begin
							rem_q   <= {len_hi_q, data_byte};
							state_q <= pad_q ? DATA : STUFF;
						end
						STUFF:
						begin
							if (data_byte[7:6] == 2'b01)
								state_q <= STD_LO;
							else if (data_byte[7:5] == 3'b001) // 0010 pts, 0011 pts+dts
							begin
								st_q    <= 4'd1;
								state_q <= STAMP;
							end
							else if (data_byte != 8'hFF)
								state_q <= DATA; // 0F, no stamps
						end
						STD_LO: state_q <= STUFF;
						STAMP:
						begin
							st_q <= st_q + 4'd1;
							if (stamp_done)
								state_q <= DATA;
						end
						default: state_q <= DATA;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (pkt_start)
		begin
			ts_q.stream_id <= pkt_stream_id;
			ts_q.has_dts   <= 1'b0;
			ts_q.std_valid <= 1'b0;
		end
		else if (pkt_sel)
		begin
			case (state_q)
				LEN_HI: len_hi_q <= data_byte;
				STUFF:
				begin
					if (data_byte[7:6] == 2'b01)
					begin
						ts_q.std_scale      <= data_byte[5];
						ts_q.std_size[12:8] <= data_byte[4:0];
					end
					else if (data_byte[7:5] == 3'b001)
					begin
						ts_q.pts[32:30] <= data_byte[3:1];
						ts_q.has_dts    <= data_byte[4];
					end
				end
				STD_LO:
				begin
					ts_q.std_size[7:0] <= data_byte;
					ts_q.std_valid     <= 1'b1;
				end
				STAMP:
				begin
					ts_q <= ts_nxt;
					if (stamp_done)
						time_stamp <= ts_nxt;
				end
				DATA:
				begin
					if (!pad_q)
						payload <= '{stream_id: ts_q.stream_id, data: data_byte, last: last};
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: system_header_parse.sv
// parses the system header fixed fields and emits one record per stream-bound entry
`timescale 1ns/1ps
`default_nettype none

module system_header_parse (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [7:0]                  data_byte,
	input  logic                        sys_sel,
	output logic                        sys_done,
	output mpeg_sys_pkg::sys_info_t     sys_info,
	output logic                        sys_valid,
	output mpeg_sys_pkg::stream_bound_t stream_bound,
	output logic                        bound_valid
);

	logic [3:0]  idx_q;  // 0..7 fixed part, 8 in the entry list
	logic [1:0]  ent_q;  // byte within an entry
	logic        skip_q; // list ended early, drain the rest
	logic [15:0] rem_q;  // header bytes still to come
	logic        last;
	logic        zero_len;
	logic        entries;
	mpeg_sys_pkg::sys_info_t     info_q;
	mpeg_sys_pkg::stream_bound_t bound_q;

	assign entries  = (idx_q == 4'd8);
	assign last     = (idx_q >= 4'd2) && (rem_q == 16'd1);
	assign zero_len = (idx_q == 4'd1) && ({info_q.header_len[15:8], data_byte} == 16'd0);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			idx_q       <= '0;
			ent_q       <= '0;
			skip_q      <= 1'b0;
			rem_q       <= '0;
			sys_valid   <= 1'b0;
			sys_done    <= 1'b0;
			bound_valid <= 1'b0;
		end
		else
		begin
			sys_valid   <= sys_sel && (idx_q == 4'd7);
			bound_valid <= sys_sel && entries && !skip_q && (ent_q == 2'd2);
			sys_done    <= sys_sel && (last || zero_len);
			if (sys_sel)
			begin
				if (last || zero_len)
				begin
					idx_q  <= '0;
					ent_q  <= '0;
					skip_q <= 1'b0;
				end
				else
				begin
					if (!entries)
						idx_q <= idx_q + 4'd1;
					if (idx_q == 4'd1)
						rem_q <= {info_q.header_len[15:8], data_byte};
					else if (idx_q != 4'd0)
						rem_q <= rem_q - 16'd1;
					if (entries && !skip_q)
					begin
						if ((ent_q == 2'd0) && !data_byte[7])
							skip_q <= 1'b1; // not a stream id
						else
							ent_q <= (ent_q == 2'd2) ? 2'd0 : ent_q + 2'd1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (sys_sel)
		begin
			case (idx_q)
				4'd0: info_q.header_len[15:8] <= data_byte;
				4'd1: info_q.header_len[7:0] <= data_byte;
				4'd2:
				begin
					info_q.rate_bound[21:15] <= data_byte[6:0];
					info_q.marker_err        <= !data_byte[7];
				end
				4'd3: info_q.rate_bound[14:7] <= data_byte;
				4'd4:
				begin
					info_q.rate_bound[6:0] <= data_byte[7:1];
					info_q.marker_err      <= info_q.marker_err || !data_byte[0];
				end
				4'd5:
				begin
					info_q.audio_bound <= data_byte[7:2];
					info_q.fixed_flag  <= data_byte[1];
					info_q.csps_flag   <= data_byte[0];
				end
				4'd6:
				begin
					info_q.audio_lock  <= data_byte[7];
					info_q.video_lock  <= data_byte[6];
					info_q.marker_err  <= info_q.marker_err || !data_byte[5];
					info_q.video_bound <= data_byte[4:0];
				end
				4'd7: sys_info <= info_q; // reserved byte, fields complete
				default:
				begin
					if (!skip_q)
					begin
						case (ent_q)
							2'd0: bound_q.stream_id <= data_byte;
							2'd1:
							begin
								bound_q.bound_scale      <= data_byte[5];
								bound_q.bound_size[12:8] <= data_byte[4:0];
							end
							default:
							begin
								stream_bound.stream_id   <= bound_q.stream_id;
								stream_bound.bound_scale <= bound_q.bound_scale;
								stream_bound.bound_size  <= {bound_q.bound_size[12:8], data_byte};
							end
						endcase
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: pack_header_parse.sv
// parses the eight pack header bytes into SCR and mux rate and checks the marker bits
`timescale 1ns/1ps
`default_nettype none

module pack_header_parse (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [7:0]               data_byte,
	input  logic                     pack_sel,
	output logic                     pack_done,
	output mpeg_sys_pkg::pack_info_t pack_info,
	output logic                     pack_valid
);

	logic [2:0]  cnt_q; // byte index within the header
	logic [32:0] scr_q;
	logic [21:7] mux_q; // low seven bits come with the last byte
	logic        err_q;
	logic        last;

	assign last = pack_sel && (cnt_q == 3'd7);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt_q      <= '0;
			pack_valid <= 1'b0;
			pack_done  <= 1'b0;
		end
		else
		begin
			pack_valid <= last;
			pack_done  <= last;
			if (pack_sel)
				cnt_q <= cnt_q + 3'd1; // wraps to 0 after byte 8
		end
	end

	always_ff @(posedge clk)
	begin
		if (pack_sel)
		begin
			case (cnt_q)
				3'd0:
				begin
					scr_q[32:30] <= data_byte[3:1];
					err_q        <= (data_byte[7:4] != 4'b0010) || !data_byte[0];
				end
				3'd1: scr_q[29:22] <= data_byte;
				3'd2:
				begin
					scr_q[21:15] <= data_byte[7:1];
					err_q        <= err_q || !data_byte[0];
				end
				3'd3: scr_q[14:7] <= data_byte;
				3'd4:
				begin
					scr_q[6:0] <= data_byte[7:1];
					err_q      <= err_q || !data_byte[0];
				end
				3'd5:
				begin
					mux_q[21:15] <= data_byte[6:0];
					err_q        <= err_q || !data_byte[7]; // leading marker
				end
				3'd6: mux_q[14:7] <= data_byte;
				default:
				begin
					pack_info.scr        <= scr_q;
					pack_info.mux_rate   <= {mux_q, data_byte[7:1]};
					pack_info.marker_err <= err_q || !data_byte[0];
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: start_code_decode.sv
// hunts for 00 00 01 start codes, classifies the code byte and routes later bytes to one parser
`timescale 1ns/1ps
`default_nettype none

module start_code_decode (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] data_byte,
	input  logic       byte_valid,
	input  logic       pack_done,
	input  logic       sys_done,
	input  logic       pkt_done,
	output logic       pack_sel,
	output logic       sys_sel,
	output logic       pkt_sel,
	output logic       pkt_start,
	output logic [7:0] pkt_stream_id,
	output logic       stream_end
);

	mpeg_sys_pkg::layer_e layer_q;
	logic [1:0] zeros_q;  // run of zero bytes, saturates at 2
	logic       prefix_q; // full prefix seen, next byte is the code
	logic       layer_done;
	logic       code_strobe;

	assign layer_done  = pack_done | sys_done | pkt_done;
	assign code_strobe = byte_valid && (layer_q == mpeg_sys_pkg::HUNT) && prefix_q;

	assign pack_sel = byte_valid && (layer_q == mpeg_sys_pkg::PACK);
	assign sys_sel  = byte_valid && (layer_q == mpeg_sys_pkg::SYSTEM);
	assign pkt_sel  = byte_valid && (layer_q == mpeg_sys_pkg::PACKET);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			layer_q    <= mpeg_sys_pkg::HUNT;
			zeros_q    <= '0;
			prefix_q   <= 1'b0;
			pkt_start  <= 1'b0;
			stream_end <= 1'b0;
		end
		else
		begin
			pkt_start  <= 1'b0;
			stream_end <= 1'b0;
			if (layer_done)
			begin
				layer_q  <= mpeg_sys_pkg::HUNT; // parser finished, forget old prefix bytes
				zeros_q  <= '0;
				prefix_q <= 1'b0;
			end
			else if (code_strobe)
			begin
				prefix_q <= 1'b0;
				zeros_q  <= (data_byte == 8'h00) ? 2'd1 : 2'd0;
				if (data_byte == mpeg_sys_pkg::CODE_PACK)
					layer_q <= mpeg_sys_pkg::PACK;
				else if (data_byte == mpeg_sys_pkg::CODE_SYSTEM)
					layer_q <= mpeg_sys_pkg::SYSTEM;
				else if (data_byte == mpeg_sys_pkg::CODE_END)
				begin
					layer_q    <= mpeg_sys_pkg::ENDED; // held until reset
					stream_end <= 1'b1;
				end
				else if (data_byte >= 8'hBC) // stream ids BC..FF
				begin
					layer_q   <= mpeg_sys_pkg::PACKET;
					pkt_start <= 1'b1;
				end
			end
			else if (byte_valid && (layer_q == mpeg_sys_pkg::HUNT))
			begin
				if (data_byte == 8'h00)
				begin
					if (zeros_q != 2'd2)
						zeros_q <= zeros_q + 2'd1;
				end
				else if ((data_byte == 8'h01) && (zeros_q == 2'd2))
				begin
					prefix_q <= 1'b1;
					zeros_q  <= '0;
				end
				else
					zeros_q <= '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (code_strobe)
			pkt_stream_id <= data_byte;
	end

endmodule

`default_nettype wire

// File: bit_deserializer.sv
// packs the enabled serial input bits into bytes and strobes each completed byte
`timescale 1ns/1ps
`default_nettype none

module bit_deserializer #(
	parameter bit LSB_FIRST = 1'b1
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       bit_en,
	input  logic       bit_in,
	output logic [7:0] data_byte,
	output logic       byte_valid
);

	logic [7:0] shift_q;
	logic [2:0] cnt_q; // bits taken in the current byte

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt_q      <= '0;
			byte_valid <= 1'b0;
		end
		else
		begin
			byte_valid <= bit_en && (cnt_q == 3'd7); // eighth bit just taken
			if (bit_en)
				cnt_q <= cnt_q + 3'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bit_en)
		begin
			if (LSB_FIRST)
				shift_q <= {bit_in, shift_q[7:1]};
			else
				shift_q <= {shift_q[6:0], bit_in};
		end
	end

	assign data_byte = shift_q; // holds through the byte_valid cycle

endmodule

`default_nettype wire

// File: mpeg_sys_pkg.sv
// shared layer enum, start-code constants and output record types for the MPEG-1 system demux
`default_nettype none

package mpeg_sys_pkg;

	// decoder layer, selects which parser receives the byte strobes
	typedef enum logic [2:0]
	{
		HUNT,
		PACK,
		SYSTEM,
		PACKET,
		ENDED
	} layer_e;

	localparam logic [7:0] CODE_PACK      = 8'hBA;
	localparam logic [7:0] CODE_SYSTEM    = 8'hBB;
	localparam logic [7:0] CODE_END       = 8'hB9;
	localparam logic [7:0] STREAM_PADDING = 8'hBF; // no STD or time-stamp fields

	typedef struct packed
	{
		logic [32:0] scr;
		logic [21:0] mux_rate;
		logic        marker_err;
	} pack_info_t;

	typedef struct packed
	{
		logic [15:0] header_len;
		logic [21:0] rate_bound;
		logic [5:0]  audio_bound;
		logic        fixed_flag;
		logic        csps_flag;
		logic        audio_lock;
		logic        video_lock;
		logic [4:0]  video_bound;
		logic        marker_err;
	} sys_info_t;

	// one stream-bound entry of the system header
	typedef struct packed
	{
		logic [7:0]  stream_id;
		logic        bound_scale;
		logic [12:0] bound_size;
	} stream_bound_t;

	typedef struct packed
	{
		logic [7:0]  stream_id;
		logic [32:0] pts;
		logic [32:0] dts;
		logic        has_dts;
		logic        std_scale;
		logic [12:0] std_size;
		logic        std_valid; // STD buffer fields were present
	} time_stamp_t;

	typedef struct packed
	{
		logic [7:0] stream_id;
		logic [7:0] data;
		logic       last; // final byte of the packet
	} payload_t;

endpackage

`default_nettype wire
